// ==== common/axi_pkg.sv ====
package axi_pkg;

    // --------------------------------------------------
    // Response and burst codes
    // --------------------------------------------------
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;
    localparam logic [1:0] AXI_BURST_INCR  = 2'b01;

    // --------------------------------------------------
    // Channel payloads
    // --------------------------------------------------

    // Shared by AW and AR
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
        logic [3:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

endpackage

// ==== common/lsu_pkg.sv ====
package lsu_pkg;

    // --------------------------------------------------
    // Data memory geometry
    // --------------------------------------------------
    localparam int DATA_MEM_BYTES = 1024;
    localparam int DATA_MEM_WORDS = DATA_MEM_BYTES / 4;
    localparam int MEM_INDEX_W    = $clog2(DATA_MEM_WORDS);

    // Access size codes, same encoding as AXI size
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // --------------------------------------------------
    // Issue stage encodings
    // --------------------------------------------------
    typedef enum logic [7:0] {
        INST_ALU    = 8'd0,
        INST_LOAD   = 8'd1,
        INST_STORE  = 8'd2,
        INST_BRANCH = 8'd3
    } inst_type_e;

    typedef enum logic [7:0] {
        LSU_OP_NONE = 8'd0,
        LSU_OP_LB   = 8'd1,
        LSU_OP_LH   = 8'd2,
        LSU_OP_LW   = 8'd3,
        LSU_OP_LBU  = 8'd4,
        LSU_OP_LHU  = 8'd5,
        LSU_OP_SB   = 8'd6,
        LSU_OP_SH   = 8'd7,
        LSU_OP_SW   = 8'd8
    } lsu_op_e;

    // Decoded request, registered by the execute stage
    typedef struct packed {
        logic        write;
        logic        sign_ext;
        logic [1:0]  size;
        logic [1:0]  lane;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic        misaligned;
    } lsu_req_t;

endpackage

// ==== filelist.f ====
common/axi_pkg.sv
common/lsu_pkg.sv
lsu/lsu_decode.sv
lsu/lsu_axi_master.sv
lsu/lsu_load_align.sv
source/axi_sram.sv
source/lsu_top.sv
testbench/lsu_checker.sv
testbench/lsu_tb.sv

// ==== lsu/lsu_axi_master.sv ====
`timescale 1ns/100ps

module lsu_axi_master
    import axi_pkg::*;
    import lsu_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    input  logic        valid_pre_i,
    input  inst_type_e  inst_type_i,
    input  lsu_req_t    req_i,
    output logic        ready_pre_o,

    output axi_addr_t   aw_o,
    output logic        awvalid_o,
    input  logic        awready_i,
    output axi_w_t      w_o,
    output logic        wvalid_o,
    input  logic        wready_i,
    input  axi_b_t      b_i,
    input  logic        bvalid_i,
    output logic        bready_o,
    output axi_addr_t   ar_o,
    output logic        arvalid_o,
    input  logic        arready_i,
    input  axi_r_t      r_i,
    input  logic        rvalid_i,
    output logic        rready_o,

    output logic        capture_o,
    output lsu_req_t    req_o,
    output logic [31:0] rdata_o,
    output logic        fault_bus_o,
    input  logic        done_i,

    output logic [31:0] load_count_o,
    output logic [31:0] store_count_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_AW_W,
        ST_WAIT_B,
        ST_WAIT_AR,
        ST_WAIT_R,
        ST_HOLD
    } state_e;

    state_e    state_q;
    state_e    state_d;
    lsu_req_t  req_q;
    logic      aw_done_q;
    logic      w_done_q;
    logic      skip_q;
    logic      accept;
    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;
    logic      ar_fire;
    logic      r_fire;
    axi_addr_t addr_chan;

    assign accept  = valid_pre_i && ready_pre_o
                   && (inst_type_i == INST_LOAD || inst_type_i == INST_STORE);
    assign aw_fire = awvalid_o && awready_i;
    assign w_fire  = wvalid_o && wready_i;
    assign b_fire  = bvalid_i && bready_o;
    assign ar_fire = arvalid_o && arready_i;
    assign r_fire  = rvalid_i && rready_o;

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    // Misaligned requests never reach the bus
                    if (req_i.misaligned) begin
                        state_d = ST_HOLD;
                    end else if (req_i.write) begin
                        state_d = ST_WAIT_AW_W;
                    end else begin
                        state_d = ST_WAIT_AR;
                    end
                end
            end
            ST_WAIT_AW_W: begin
                if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
                    state_d = ST_WAIT_B;
                end
            end
            ST_WAIT_B: if (b_fire) state_d = ST_HOLD;
            ST_WAIT_AR: if (ar_fire) state_d = ST_WAIT_R;
            ST_WAIT_R: if (r_fire) state_d = ST_HOLD;
            ST_HOLD: if (done_i) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q       <= ST_IDLE;
            aw_done_q     <= 1'b0;
            w_done_q      <= 1'b0;
            skip_q        <= 1'b0;
            load_count_o  <= '0;
            store_count_o <= '0;
        end else begin
            state_q   <= state_d;
            aw_done_q <= (state_d == ST_WAIT_AW_W) && (aw_done_q || aw_fire);
            w_done_q  <= (state_d == ST_WAIT_AW_W) && (w_done_q || w_fire);
            skip_q    <= accept && req_i.misaligned;
            // One capture per operation, faults included
            if (capture_o) begin
                if (req_q.write) begin
                    store_count_o <= store_count_o + 32'd1;
                end else begin
                    load_count_o <= load_count_o + 32'd1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

    // --------------------------------------------------
    // AXI channel drive
    // --------------------------------------------------
    assign addr_chan = '{
        addr:  req_q.addr,
        id:    4'd0,
        len:   8'd0,
        size:  {1'b0, req_q.size},
        burst: AXI_BURST_INCR
    };

    assign aw_o      = addr_chan;
    assign ar_o      = addr_chan;
    assign w_o       = '{data: req_q.wdata, strb: req_q.strb, last: 1'b1};
    assign awvalid_o = (state_q == ST_WAIT_AW_W) && !aw_done_q;
    assign wvalid_o  = (state_q == ST_WAIT_AW_W) && !w_done_q;
    assign bready_o  = (state_q == ST_WAIT_B);
    assign arvalid_o = (state_q == ST_WAIT_AR);
    assign rready_o  = (state_q == ST_WAIT_R);

    assign ready_pre_o = (state_q == ST_IDLE);

    // Result stage hand-off
    assign capture_o   = skip_q || r_fire || b_fire;
    assign req_o       = req_q;
    assign rdata_o     = r_i.data;
    assign fault_bus_o = (r_fire && r_i.resp != AXI_RESP_OKAY)
                       || (b_fire && b_i.resp != AXI_RESP_OKAY);

endmodule

// ==== lsu/lsu_decode.sv ====
`timescale 1ns/100ps

module lsu_decode
    import lsu_pkg::*;
(
    input  lsu_op_e     op_i,
    input  logic [31:0] imm_i,
    input  logic [31:0] rdata1_i,
    input  logic [31:0] rdata2_i,
    output lsu_req_t    req_o
);

    logic [31:0] addr;
    logic [1:0]  lane;
    logic [4:0]  lane_shift;

    assign addr       = rdata1_i + imm_i;
    assign lane       = addr[1:0];
    assign lane_shift = {lane, 3'b000};

    always_comb begin
        req_o          = '0;
        req_o.addr     = addr;
        req_o.lane     = lane;

        // Direction, size and sign
        case (op_i)
            LSU_OP_LB: begin
                req_o.size     = SIZE_BYTE;
                req_o.sign_ext = 1'b1;
            end
            LSU_OP_LBU: begin
                req_o.size = SIZE_BYTE;
            end
            LSU_OP_LH: begin
                req_o.size     = SIZE_HALF;
                req_o.sign_ext = 1'b1;
            end
            LSU_OP_LHU: begin
                req_o.size = SIZE_HALF;
            end
            LSU_OP_LW: begin
                req_o.size = SIZE_WORD;
            end
            LSU_OP_SB: begin
                req_o.size  = SIZE_BYTE;
                req_o.write = 1'b1;
            end
            LSU_OP_SH: begin
                req_o.size  = SIZE_HALF;
                req_o.write = 1'b1;
            end
            LSU_OP_SW: begin
                req_o.size  = SIZE_WORD;
                req_o.write = 1'b1;
            end
            default: begin
                req_o.size = SIZE_BYTE;
            end
        endcase

        // Store data moved into its lane, strobes follow
        if (req_o.write) begin
            case (req_o.size)
                SIZE_BYTE: begin
                    req_o.wdata = {24'h0, rdata2_i[7:0]} << lane_shift;
                    req_o.strb  = 4'b0001 << lane;
                end
                SIZE_HALF: begin
                    req_o.wdata = {16'h0, rdata2_i[15:0]} << lane_shift;
                    req_o.strb  = 4'b0011 << lane;
                end
                default: begin
                    req_o.wdata = rdata2_i;
                    req_o.strb  = 4'b1111;
                end
            endcase
        end

        req_o.misaligned = (req_o.size == SIZE_HALF && addr[0])
                         || (req_o.size == SIZE_WORD && addr[1:0] != 2'b00);
    end

endmodule

// ==== lsu/lsu_load_align.sv ====
`timescale 1ns/100ps

module lsu_load_align
    import lsu_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        capture_i,
    input  lsu_req_t    req_i,
    input  logic [31:0] rdata_i,
    input  logic        fault_bus_i,
    input  logic        ready_post_i,
    output logic        valid_post_o,
    output logic [31:0] mem_result_o,
    output logic        fault_o,
    output logic        done_o
);

    logic [31:0] shifted;
    logic [31:0] aligned;
    logic        fault_d;
    logic        valid_q;

    // Bring the addressed lane down to bit 0
    assign shifted = rdata_i >> {req_i.lane, 3'b000};

    always_comb begin
        case (req_i.size)
            SIZE_BYTE: aligned = {{24{req_i.sign_ext & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: aligned = {{16{req_i.sign_ext & shifted[15]}}, shifted[15:0]};
            default:   aligned = rdata_i;
        endcase
    end

    assign fault_d = req_i.misaligned || fault_bus_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
            fault_o <= 1'b0;
        end else if (capture_i) begin
            valid_q <= 1'b1;
            fault_o <= fault_d;
        end else if (done_o) begin
            valid_q <= 1'b0;
        end
    end

    // Stores and faults return zero
    always_ff @(posedge clock) begin
        if (capture_i) begin
            mem_result_o <= (fault_d || req_i.write) ? 32'h0 : aligned;
        end
    end

    assign valid_post_o = valid_q;
    assign done_o       = valid_q && ready_post_i;

endmodule

// ==== source/axi_sram.sv ====
`timescale 1ns/100ps

module axi_sram
    import axi_pkg::*;
    import lsu_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    input  axi_addr_t aw_i,
    input  logic      awvalid_i,
    output logic      awready_o,
    input  axi_w_t    w_i,
    input  logic      wvalid_i,
    output logic      wready_o,
    output axi_b_t    b_o,
    output logic      bvalid_o,
    input  logic      bready_i,

    input  axi_addr_t ar_i,
    input  logic      arvalid_i,
    output logic      arready_o,
    output axi_r_t    r_o,
    output logic      rvalid_o,
    input  logic      rready_i
);

    logic [31:0]            mem [DATA_MEM_WORDS];
    logic [MEM_INDEX_W-1:0] wr_index;
    logic [MEM_INDEX_W-1:0] rd_index;
    logic                   wr_in_range;
    logic                   rd_in_range;

    assign wr_index    = aw_i.addr[MEM_INDEX_W+1:2];
    assign rd_index    = ar_i.addr[MEM_INDEX_W+1:2];
    assign wr_in_range = aw_i.addr < DATA_MEM_BYTES;
    assign rd_in_range = ar_i.addr < DATA_MEM_BYTES;

    // --------------------------------------------------
    // Write path
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            for (int i = 0; i < DATA_MEM_WORDS; i++) begin
                mem[i] <= 32'h0;
            end
        end else begin
            // Address and data accepted together, one cycle after valid
            awready_o <= awvalid_i && wvalid_i && !awready_o && !bvalid_o;
            wready_o  <= awvalid_i && wvalid_i && !awready_o && !bvalid_o;
            if (awvalid_i && awready_o) begin
                if (wr_in_range) begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (w_i.strb[lane]) begin
                            mem[wr_index][lane*8 +: 8] <= w_i.data[lane*8 +: 8];
                        end
                    end
                end
                bvalid_o <= 1'b1;
                b_o      <= '{resp: wr_in_range ? AXI_RESP_OKAY : AXI_RESP_SLVERR, id: 4'd0};
            end else if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
        end else begin
            arready_o <= arvalid_i && !arready_o && !rvalid_o;
            if (arvalid_i && arready_o) begin
                rvalid_o   <= 1'b1;
                r_o.data   <= rd_in_range ? mem[rd_index] : 32'h0;
                r_o.resp   <= rd_in_range ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
                r_o.last   <= 1'b1;
                r_o.id     <= 4'd0;
            end else if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

endmodule

// ==== source/lsu_top.sv ====
`timescale 1ns/100ps

module lsu_top
    import axi_pkg::*;
    import lsu_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    input  logic        valid_pre_i,
    input  inst_type_e  inst_type_i,
    input  lsu_op_e     lsu_op_i,
    input  logic [31:0] imm_i,
    input  logic [31:0] rdata1_i,
    input  logic [31:0] rdata2_i,
    output logic        ready_pre_o,

    input  logic        ready_post_i,
    output logic        valid_post_o,
    output logic [31:0] mem_result_o,
    output logic        fault_o,

    output logic [31:0] load_count_o,
    output logic [31:0] store_count_o
);

    lsu_req_t    dec_req;
    lsu_req_t    ex_req;
    logic        capture;
    logic [31:0] ex_rdata;
    logic        fault_bus;
    logic        done;

    // AXI between master and memory
    axi_addr_t   aw;
    axi_addr_t   ar;
    axi_w_t      w;
    axi_b_t      b;
    axi_r_t      r;
    logic        awvalid;
    logic        awready;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic        arvalid;
    logic        arready;
    logic        rvalid;
    logic        rready;

    lsu_decode u_decode (
        .op_i     (lsu_op_i),
        .imm_i    (imm_i),
        .rdata1_i (rdata1_i),
        .rdata2_i (rdata2_i),
        .req_o    (dec_req)
    );

    lsu_axi_master u_master (
        .clock         (clock),
        .reset         (reset),
        .valid_pre_i   (valid_pre_i),
        .inst_type_i   (inst_type_i),
        .req_i         (dec_req),
        .ready_pre_o   (ready_pre_o),
        .aw_o          (aw),
        .awvalid_o     (awvalid),
        .awready_i     (awready),
        .w_o           (w),
        .wvalid_o      (wvalid),
        .wready_i      (wready),
        .b_i           (b),
        .bvalid_i      (bvalid),
        .bready_o      (bready),
        .ar_o          (ar),
        .arvalid_o     (arvalid),
        .arready_i     (arready),
        .r_i           (r),
        .rvalid_i      (rvalid),
        .rready_o      (rready),
        .capture_o     (capture),
        .req_o         (ex_req),
        .rdata_o       (ex_rdata),
        .fault_bus_o   (fault_bus),
        .done_i        (done),
        .load_count_o  (load_count_o),
        .store_count_o (store_count_o)
    );

    lsu_load_align u_align (
        .clock        (clock),
        .reset        (reset),
        .capture_i    (capture),
        .req_i        (ex_req),
        .rdata_i      (ex_rdata),
        .fault_bus_i  (fault_bus),
        .ready_post_i (ready_post_i),
        .valid_post_o (valid_post_o),
        .mem_result_o (mem_result_o),
        .fault_o      (fault_o),
        .done_o       (done)
    );

    axi_sram u_sram (
        .clock     (clock),
        .reset     (reset),
        .aw_i      (aw),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .w_i       (w),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .b_o       (b),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .ar_i      (ar),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .r_o       (r),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

endmodule

// ==== testbench/lsu_checker.sv ====
`timescale 1ns/100ps

module lsu_checker
    import axi_pkg::*;
(
    input logic      clock,
    input logic      reset,
    input axi_addr_t aw_i,
    input logic      awvalid_i,
    input logic      awready_i,
    input axi_w_t    w_i,
    input logic      wvalid_i,
    input logic      wready_i,
    input axi_addr_t ar_i,
    input logic      arvalid_i,
    input logic      arready_i,
    input logic      bready_i,
    input logic      rready_i,
    input logic      ready_pre_i,
    input logic      done_i
);

    // --------------------------------------------------
    // AXI channel rules
    // --------------------------------------------------
    aw_stable: assert property (@(posedge clock) disable iff (reset)
        awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
        else $error("AW valid dropped or payload changed before awready");

    w_stable: assert property (@(posedge clock) disable iff (reset)
        wvalid_i && !wready_i |=> wvalid_i && $stable(w_i))
        else $error("W valid dropped or payload changed before wready");

    ar_stable: assert property (@(posedge clock) disable iff (reset)
        arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
        else $error("AR valid dropped or payload changed before arready");

    aw_w_together: assert property (@(posedge clock) disable iff (reset)
        $rose(awvalid_i) |-> $rose(wvalid_i))
        else $error("awvalid rose without wvalid");

    rd_wr_exclusive: assert property (@(posedge clock) disable iff (reset)
        !((awvalid_i || wvalid_i || bready_i) && (arvalid_i || rready_i)))
        else $error("read and write active at the same time");

    // --------------------------------------------------
    // Writeback side as seen from the master
    // --------------------------------------------------
    // Taking the result frees the unit on that same edge
    idle_after_done: assert property (@(posedge clock) disable iff (reset)
        done_i |=> ready_pre_i)
        else $error("unit did not return to idle when the result was taken");

    done_when_busy: assert property (@(posedge clock) disable iff (reset)
        done_i |-> !ready_pre_i)
        else $error("result taken while the unit was idle");

endmodule

bind lsu_axi_master lsu_checker u_checker (
    .clock       (clock),
    .reset       (reset),
    .aw_i        (aw_o),
    .awvalid_i   (awvalid_o),
    .awready_i   (awready_i),
    .w_i         (w_o),
    .wvalid_i    (wvalid_o),
    .wready_i    (wready_i),
    .ar_i        (ar_o),
    .arvalid_i   (arvalid_o),
    .arready_i   (arready_i),
    .bready_i    (bready_o),
    .rready_i    (rready_o),
    .ready_pre_i (ready_pre_o),
    .done_i      (done_i)
);

// ==== testbench/lsu_tb.sv ====
`timescale 1ns/100ps

module lsu_tb
    import lsu_pkg::*;
();

    localparam logic [31:0] SEED    = 32'h35a888a1;
    localparam int          TIMEOUT = 200;

    logic        clock = 1'b0;
    logic        reset;
    logic        valid_pre_i;
    inst_type_e  inst_type_i;
    lsu_op_e     lsu_op_i;
    logic [31:0] imm_i;
    logic [31:0] rdata1_i;
    logic [31:0] rdata2_i;
    logic        ready_pre_o;
    logic        ready_post_i;
    logic        valid_post_o;
    logic [31:0] mem_result_o;
    logic        fault_o;
    logic [31:0] load_count_o;
    logic [31:0] store_count_o;

    logic [7:0]  mem_model [DATA_MEM_BYTES];
    logic [32:0] expected_q [$];
    logic [31:0] stim_seed = SEED;
    logic [31:0] hold_seed = SEED;
    int          mismatch_count = 0;
    int          other_count = 0;
    int          issued = 0;
    int          completed = 0;
    int          loads_issued = 0;
    int          stores_issued = 0;

    always #20 clock = ~clock;

    lsu_top DUT (
        .clock         (clock),
        .reset         (reset),
        .valid_pre_i   (valid_pre_i),
        .inst_type_i   (inst_type_i),
        .lsu_op_i      (lsu_op_i),
        .imm_i         (imm_i),
        .rdata1_i      (rdata1_i),
        .rdata2_i      (rdata2_i),
        .ready_pre_o   (ready_pre_o),
        .ready_post_i  (ready_post_i),
        .valid_post_o  (valid_post_o),
        .mem_result_o  (mem_result_o),
        .fault_o       (fault_o),
        .load_count_o  (load_count_o),
        .store_count_o (store_count_o)
    );

    // --------------------------------------------------
    // Helpers and reference model
    // --------------------------------------------------
    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        // Low bits of an LCG cycle quickly, fold the high half in
        return state ^ (state >> 16);
    endfunction

    function automatic int op_size(input lsu_op_e op);
        case (op)
            LSU_OP_LB, LSU_OP_LBU, LSU_OP_SB: return 1;
            LSU_OP_LH, LSU_OP_LHU, LSU_OP_SH: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic is_store(input lsu_op_e op);
        return op == LSU_OP_SB || op == LSU_OP_SH || op == LSU_OP_SW;
    endfunction

    // Returns {fault, value}; stores always give a zero value
    function automatic logic [32:0] expected_result(input lsu_op_e op, input logic [31:0] addr,
            input logic [31:0] data, input logic [7:0] model [DATA_MEM_BYTES]);
        int          size;
        logic        fault;
        logic [31:0] value;
        size  = op_size(op);
        fault = (addr % size != 0) || (addr >= DATA_MEM_BYTES);
        value = 32'h0;
        if (!fault && !is_store(op)) begin
            for (int i = 0; i < size; i++) begin
                value[i*8 +: 8] = model[addr + i];
            end
            if (op == LSU_OP_LB) begin
                value = {{24{value[7]}}, value[7:0]};
            end
            if (op == LSU_OP_LH) begin
                value = {{16{value[15]}}, value[15:0]};
            end
        end
        return {fault, value};
    endfunction

    task automatic end_on_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("errors: %0d mismatch, %0d other", mismatch_count, other_count + 1);
        $display("test failed");
        $finish;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clock);
        while (!ready_pre_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                end_on_timeout("ready_pre_o stayed low");
            end
            @(negedge clock);
        end
    endtask

    task automatic issue_op(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] r;
        logic [32:0] exp_val;
        wait_idle();
        r           = lcg_next(stim_seed);
        imm_i       = {{20{r[11]}}, r[11:0]};
        rdata1_i    = addr - imm_i;
        rdata2_i    = data;
        lsu_op_i    = op;
        inst_type_i = is_store(op) ? INST_STORE : INST_LOAD;
        valid_pre_i = 1'b1;
        exp_val     = expected_result(op, addr, data, mem_model);
        expected_q.push_back(exp_val);
        issued++;
        if (is_store(op)) begin
            stores_issued++;
            // Faulting stores leave memory alone
            if (!exp_val[32]) begin
                for (int i = 0; i < op_size(op); i++) begin
                    mem_model[addr + i] = data[i*8 +: 8];
                end
            end
        end else begin
            loads_issued++;
        end
        @(negedge clock);
        valid_pre_i = 1'b0;
    endtask

    // ALU class on the issue side must be ignored
    task automatic issue_alu();
        wait_idle();
        inst_type_i = INST_ALU;
        lsu_op_i    = LSU_OP_LW;
        rdata1_i    = 32'h10;
        imm_i       = 32'h0;
        valid_pre_i = 1'b1;
        @(negedge clock);
        valid_pre_i = 1'b0;
        if (ready_pre_o !== 1'b1) begin
            other_count++;
            $display("error at %0t: ALU issue was taken by the unit", $time);
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin : stimulus
        logic [31:0] word_addr [8];
        logic [31:0] r;
        logic [31:0] base;
        lsu_op_e     op;
        int          waited;
        valid_pre_i  = 1'b0;
        inst_type_i  = INST_ALU;
        lsu_op_i     = LSU_OP_NONE;
        imm_i        = 32'h0;
        rdata1_i     = 32'h0;
        rdata2_i     = 32'h0;
        ready_post_i = 1'b0;
        reset        = 1'b1;
        for (int i = 0; i < DATA_MEM_BYTES; i++) begin
            mem_model[i] = 8'h0;
        end
        repeat (16) @(negedge clock);
        reset = 1'b0;

        // Word stores, then word loads of the same places
        for (int i = 0; i < 8; i++) begin
            word_addr[i] = (lcg_next(stim_seed) % (DATA_MEM_BYTES / 4)) * 4;
            issue_op(LSU_OP_SW, word_addr[i], lcg_next(stim_seed));
        end
        for (int i = 0; i < 8; i++) begin
            issue_op(LSU_OP_LW, word_addr[i], 32'h0);
        end
        issue_alu();

        // Mixed sizes packed into a small window
        for (int i = 0; i < 60; i++) begin
            r    = lcg_next(stim_seed);
            op   = lsu_op_e'(1 + r % 8);
            base = (r >> 8) % 64;
            base = base & ~(op_size(op) - 1);
            issue_op(op, base, lcg_next(stim_seed));
        end
        issue_alu();

        // Misaligned accesses, each followed by a word load
        for (int i = 0; i < 12; i++) begin
            r    = lcg_next(stim_seed);
            base = ((r >> 8) % 64) & ~32'h3;
            case (r % 4)
                0: op = LSU_OP_LH;
                1: op = LSU_OP_SH;
                2: op = LSU_OP_LW;
                default: op = LSU_OP_SW;
            endcase
            if (op_size(op) == 2) begin
                issue_op(op, base + (r[20] ? 32'd3 : 32'd1), lcg_next(stim_seed));
            end else begin
                issue_op(op, base + 32'd1 + (r >> 16) % 3, lcg_next(stim_seed));
            end
            issue_op(LSU_OP_LW, base, 32'h0);
        end

        // Beyond the end of memory
        for (int i = 0; i < 10; i++) begin
            r  = lcg_next(stim_seed);
            op = lsu_op_e'(1 + r % 8);
            issue_op(op, DATA_MEM_BYTES + ((r >> 8) % 256) * 4, lcg_next(stim_seed));
        end
        issue_alu();

        waited = 0;
        while (completed != issued) begin
            waited++;
            if (waited > TIMEOUT) begin
                end_on_timeout("results still pending at the end");
            end
            @(negedge clock);
        end
        @(negedge clock);
        if (load_count_o !== loads_issued) begin
            mismatch_count++;
            $display("mismatch at %0t: load_count_o expected %0d got %0d",
                     $time, loads_issued, load_count_o);
        end
        if (store_count_o !== stores_issued) begin
            mismatch_count++;
            $display("mismatch at %0t: store_count_o expected %0d got %0d",
                     $time, stores_issued, store_count_o);
        end

        $display("errors: %0d mismatch, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // --------------------------------------------------
    // Result comparison with random back-pressure
    // --------------------------------------------------
    initial begin : compare_results
        logic [32:0] exp_val;
        logic [31:0] held_result;
        logic        held_fault;
        logic [31:0] r;
        int          waited;
        int          hold_cycles;
        forever begin
            waited = 0;
            @(negedge clock);
            while (reset || !valid_post_o) begin
                if (expected_q.size() != 0) begin
                    waited++;
                end
                if (waited > TIMEOUT) begin
                    end_on_timeout("no valid_post_o for a pending operation");
                end
                @(negedge clock);
            end
            if (expected_q.size() == 0) begin
                other_count++;
                $display("error at %0t: result appeared with no operation pending", $time);
            end else begin
                exp_val = expected_q.pop_front();
                if (mem_result_o !== exp_val[31:0]) begin
                    mismatch_count++;
                    $display("mismatch at %0t: mem_result_o expected %h got %h",
                             $time, exp_val[31:0], mem_result_o);
                end
                if (fault_o !== exp_val[32]) begin
                    mismatch_count++;
                    $display("mismatch at %0t: fault_o expected %b got %b",
                             $time, exp_val[32], fault_o);
                end
            end
            held_result = mem_result_o;
            held_fault  = fault_o;
            r           = lcg_next(hold_seed);
            hold_cycles = r[3] ? r % 6 : 0;
            for (int i = 0; i < hold_cycles; i++) begin
                @(negedge clock);
                if (mem_result_o !== held_result) begin
                    mismatch_count++;
                    $display("mismatch at %0t: mem_result_o expected %h got %h",
                             $time, held_result, mem_result_o);
                end
                if (fault_o !== held_fault) begin
                    mismatch_count++;
                    $display("mismatch at %0t: fault_o expected %b got %b",
                             $time, held_fault, fault_o);
                end
                if (valid_post_o !== 1'b1 || ready_pre_o !== 1'b0) begin
                    other_count++;
                    $display("error at %0t: unit did not hold while the result waited", $time);
                end
            end
            ready_post_i = 1'b1;
            @(negedge clock);
            ready_post_i = 1'b0;
            completed++;
        end
    end

endmodule
